// File: bench/hid_tb.sv
//############################################################
// testbench for hid_top with default parameters only
// irq is allowed to rise up to 2 cycles after a port change
//############################################################
`timescale 1ns/1ps

module hid_tb;

  import hid_pkg::*;

  localparam int          CLK_PERIOD     = 10;
  localparam logic [15:0] STATUS_WORD    = 16'h5c42;
  localparam int          KEY_EVENTS     = 48;
  localparam int          MOUSE_FRAMES   = 12;
  localparam int          JOY_FRAMES     = 16;
  // the rest covers status, unknown and DB9 frames
  localparam int          FRAME_COUNT    = KEY_EVENTS + MOUSE_FRAMES + JOY_FRAMES + 24;
  localparam int          TIMEOUT_CYCLES = FRAME_COUNT * 40 + 256 + 1000;

  logic       clk;
  logic       reset;
  logic       data_in_strobe;
  logic       data_in_start;
  logic [7:0] data_in;
  logic [7:0] data_out;
  logic [5:0] db9_port;
  logic       irq;
  logic       iack;
  logic [7:0] joystick0;
  logic [7:0] joystick1;
  logic [7:0] numpad;
  logic [7:0] keyboard_matrix_out;
  logic [7:0] keyboard_matrix_in;
  logic       key_restore;
  logic [1:0] mouse_btns;
  logic [7:0] mouse_x;
  logic [7:0] mouse_y;
  logic       mouse_strobe;

  // reference model
  logic [7:0]  m_keys [8];
  logic [7:0]  m_cmd;
  logic [3:0]  m_index;
  logic [7:0]  m_device;
  logic [5:0]  m_snapshot;
  logic        m_armed;
  logic [7:0]  exp_matrix;
  logic [7:0]  exp_data;
  logic [7:0]  exp_joy0;
  logic [7:0]  exp_joy1;
  logic [7:0]  exp_numpad;
  logic        exp_restore;
  logic [1:0]  exp_btns;
  logic [7:0]  exp_x;
  logic [7:0]  exp_y;
  logic        exp_mouse_strobe;
  logic        exp_irq;
  int          irq_window;
  int          errors;
  logic [31:0] lcg_state;

  hid_top dut0 (
    .clk                 (clk),
    .reset               (reset),
    .data_in_strobe      (data_in_strobe),
    .data_in_start       (data_in_start),
    .data_in             (data_in),
    .data_out            (data_out),
    .db9_port            (db9_port),
    .irq                 (irq),
    .iack                (iack),
    .joystick0           (joystick0),
    .joystick1           (joystick1),
    .numpad              (numpad),
    .keyboard_matrix_out (keyboard_matrix_out),
    .keyboard_matrix_in  (keyboard_matrix_in),
    .key_restore         (key_restore),
    .mouse_btns          (mouse_btns),
    .mouse_x             (mouse_x),
    .mouse_y             (mouse_y),
    .mouse_strobe        (mouse_strobe)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("ERROR: simulation timed out before all tests finished");
    $display("Testbench failed");
    $finish;
  end

  matrix_check: assert property (@(posedge clk) disable iff (reset)
      keyboard_matrix_in == exp_matrix)
    else begin
      errors = errors + 1;
      $display("MISMATCH at %0t: keyboard_matrix_in %h for scan %h, expected %h",
               $time, keyboard_matrix_in, keyboard_matrix_out, exp_matrix);
    end

  mouse_check: assert property (@(posedge clk) disable iff (reset)
      {mouse_btns, mouse_x, mouse_y, mouse_strobe} == {exp_btns, exp_x, exp_y, exp_mouse_strobe})
    else begin
      errors = errors + 1;
      $display("MISMATCH at %0t: mouse btns/x/y/strobe %h %h %h %b, expected %h %h %h %b",
               $time, mouse_btns, mouse_x, mouse_y, mouse_strobe,
               exp_btns, exp_x, exp_y, exp_mouse_strobe);
    end

  joystick_check: assert property (@(posedge clk) disable iff (reset)
      {joystick0, joystick1, numpad, key_restore} ==
      {exp_joy0, exp_joy1, exp_numpad, exp_restore})
    else begin
      errors = errors + 1;
      $display("MISMATCH at %0t: joy0/joy1/numpad/restore %h %h %h %b, expected %h %h %h %b",
               $time, joystick0, joystick1, numpad, key_restore,
               exp_joy0, exp_joy1, exp_numpad, exp_restore);
    end

  reply_check: assert property (@(posedge clk) disable iff (reset) data_out == exp_data)
    else begin
      errors = errors + 1;
      $display("MISMATCH at %0t: data_out %h, expected %h", $time, data_out, exp_data);
    end

  // irq is only compared once the rise window after a port change has passed
  irq_check: assert property (@(posedge clk) disable iff (reset)
      (irq_window == 0) |-> (irq == exp_irq))
    else begin
      errors = errors + 1;
      $display("MISMATCH at %0t: irq %b, expected %b", $time, irq, exp_irq);
    end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // rows with a low select bit are ANDed, ff when none is selected
  function automatic logic [7:0] matrix_answer(input logic [7:0] select);
    logic [7:0] result;
    result = 8'hff;
    for (int i = 0; i < 8; i++) begin
      if (!select[i]) begin
        result = result & m_keys[i];
      end
    end
    return result;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
    exp_mouse_strobe = 1'b0;
    if (irq_window > 0) begin
      irq_window = irq_window - 1;
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) next_cycle();
  endtask

  task automatic set_scan(input logic [7:0] pattern);
    keyboard_matrix_out = pattern;
    exp_matrix = matrix_answer(pattern);
  endtask

  // model side of one strobed byte, called just after the edge that took it
  task automatic apply_byte(input logic start, input logic [7:0] data);
    if (start) begin
      m_cmd = data;
      m_index = 4'd1;
    end else if (m_index != 4'd0) begin
      case (m_cmd)
        CMD_STATUS: begin
          if (m_index == 4'd1) begin
            exp_data = STATUS_WORD[15:8];
          end else if (m_index == 4'd2) begin
            exp_data = STATUS_WORD[7:0];
          end
        end
        CMD_KEYBOARD: begin
          if (m_index == 4'd1) begin
            m_keys[data[2:0]][data[5:3]] = data[7];
            exp_matrix = matrix_answer(keyboard_matrix_out);
          end
        end
        CMD_MOUSE: begin
          if (m_index == 4'd1) begin
            exp_btns = data[1:0];
          end else if (m_index == 4'd2) begin
            exp_x = data;
          end else if (m_index == 4'd3) begin
            exp_y = data;
            exp_mouse_strobe = 1'b1;
          end
        end
        CMD_JOYSTICK: begin
          if (m_index == 4'd1) begin
            m_device = data;
          end else if (m_index == 4'd2) begin
            if (m_device == JOY_DEV_0) begin
              exp_joy0 = data;
            end else if (m_device == JOY_DEV_1) begin
              exp_joy1 = data;
            end else if (m_device == JOY_DEV_NUMPAD) begin
              exp_numpad = data;
              exp_restore = data[6];
            end
          end
        end
        CMD_DB9_READ: begin
          if (m_index == 4'd1) begin
            m_snapshot = db9_port;
            m_armed = 1'b1;
          end
          exp_data = {2'b00, m_snapshot};
        end
        default: ;
      endcase
      if (m_index != 4'd15) begin
        m_index = m_index + 4'd1;
      end
    end
  endtask

  task automatic strobe_byte(input logic start, input logic [7:0] data);
    logic [31:0] r;
    data_in_strobe = 1'b1;
    data_in_start = start;
    data_in = data;
    next_cycle();
    data_in_strobe = 1'b0;
    data_in_start = 1'b0;
    apply_byte(start, data);
    r = next_rand();
    // back-to-back or a random gap of up to 3 cycles
    if (!r[24]) begin
      idle(r[17:16]);
    end
  endtask

  task automatic send_frame(input logic [7:0] cmd_byte, input int count,
                            input logic [7:0] b1, input logic [7:0] b2, input logic [7:0] b3);
    strobe_byte(1'b1, cmd_byte);
    if (count > 0) strobe_byte(1'b0, b1);
    if (count > 1) strobe_byte(1'b0, b2);
    if (count > 2) strobe_byte(1'b0, b3);
  endtask

  task automatic db9_change(input logic [5:0] value, input logic ack);
    db9_port = value;
    iack = ack;
    irq_window = 2;
    next_cycle();
    iack = 1'b0;
    if (m_armed && value != m_snapshot) begin
      m_armed = 1'b0;
      exp_irq = 1'b1;
    end
    // acknowledge wins over a rise in the same cycle
    if (ack) begin
      exp_irq = 1'b0;
    end
  endtask

  task automatic pulse_iack();
    iack = 1'b1;
    next_cycle();
    iack = 1'b0;
    exp_irq = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0]  dev;
    clk_init: begin
      reset = 1'b1;
      data_in_strobe = 1'b0;
      data_in_start = 1'b0;
      data_in = 8'h00;
      db9_port = 6'h00;
      iack = 1'b0;
      keyboard_matrix_out = 8'hff;
    end
    for (int i = 0; i < 8; i++) begin
      m_keys[i] = 8'hff;
    end
    m_cmd = 8'h00;
    m_index = 4'd0;
    m_device = 8'h00;
    m_snapshot = 6'h00;
    m_armed = 1'b0;
    exp_matrix = 8'hff;
    exp_data = 8'h00;
    exp_joy0 = 8'h00;
    exp_joy1 = 8'h00;
    exp_numpad = 8'h00;
    exp_restore = 1'b0;
    exp_btns = 2'b00;
    exp_x = 8'h00;
    exp_y = 8'h00;
    exp_mouse_strobe = 1'b0;
    exp_irq = 1'b0;
    irq_window = 0;
    errors = 0;
    lcg_state = 32'h2aab464b;

    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // released matrix for every scan pattern
    for (int p = 0; p < 256; p++) begin
      set_scan(8'(p));
      next_cycle();
    end

    // payload without an open frame, and a port change before any read
    strobe_byte(1'b0, 8'h0b);
    strobe_byte(1'b0, 8'h81);
    db9_change(6'h15, 1'b0);
    idle(4);

    for (int i = 0; i < KEY_EVENTS; i++) begin
      r = next_rand();
      send_frame(CMD_KEYBOARD, 1, r[7:0], 8'h00, 8'h00);
      for (int k = 0; k < 4; k++) begin
        r = next_rand();
        // ANDing two words leaves several rows selected
        set_scan(k[0] ? r[7:0] : (r[7:0] & r[15:8]));
        next_cycle();
      end
    end

    for (int i = 0; i < MOUSE_FRAMES; i++) begin
      r = next_rand();
      send_frame(CMD_MOUSE, 3, r[7:0], r[15:8], r[23:16]);
      idle(r[26:25]);
    end
    send_frame(CMD_MOUSE, 2, 8'h02, 8'h7f, 8'h00);

    for (int i = 0; i < JOY_FRAMES; i++) begin
      r = next_rand();
      case (i % 4)
        0: dev = JOY_DEV_0;
        1: dev = JOY_DEV_1;
        2: dev = JOY_DEV_NUMPAD;
        default: dev = r[15:8] | 8'h02;
      endcase
      send_frame(CMD_JOYSTICK, r[24] ? 3 : 2, dev, r[7:0], r[23:16]);
    end

    send_frame(CMD_STATUS, 3, 8'h00, 8'h00, 8'h00);
    send_frame(8'h07, 3, 8'h11, 8'h22, 8'h33);
    send_frame(8'hff, 2, 8'h80, 8'h40, 8'h00);
    send_frame(CMD_STATUS, 2, 8'h00, 8'h00, 8'h00);

    send_frame(CMD_DB9_READ, 2, 8'h00, 8'h00, 8'h00);
    db9_change(6'h2a, 1'b0);
    idle(3);
    db9_change(6'h0f, 1'b0);
    idle(3);
    pulse_iack();
    db9_change(6'h30, 1'b0);
    idle(3);
    send_frame(CMD_DB9_READ, 1, 8'h00, 8'h00, 8'h00);
    db9_change(6'h31, 1'b1);
    idle(3);
    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      send_frame(CMD_DB9_READ, 1 + (i % 3), r[7:0], 8'h00, 8'h00);
      db9_change(m_snapshot ^ (r[13:8] | 6'h01), 1'b0);
      idle(3);
      pulse_iack();
      idle(1);
    end

    idle(3);
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: project.f
rtl/hid_pkg.sv
rtl/hid_frame_parser.sv
rtl/hid_key_matrix.sv
rtl/hid_device_regs.sv
rtl/db9_monitor.sv
rtl/hid_reply.sv
rtl/hid_top.sv
bench/hid_tb.sv

// File: rtl/db9_monitor.sv
//############################################################
// DB9 change detector, one irq per re-arm
// db9_port must already be synchronous to clk
//############################################################
`timescale 1ns/1ps

module db9_monitor #(
  parameter int DB9_WIDTH = 6
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [DB9_WIDTH-1:0] db9_port,
  input  logic                 rearm,
  input  logic                 iack,
  output logic                 irq,
  output logic [DB9_WIDTH-1:0] db9_snapshot
);

  logic armed;

  // value last handed to the MCU
  always_ff @(posedge clk) begin
    if (rearm) begin
      db9_snapshot <= db9_port;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      armed <= 1'b0;
      irq   <= 1'b0;
    end else begin
      if (rearm) begin
        armed <= 1'b1;
      end else if (armed && db9_port != db9_snapshot) begin
        // stay quiet until the MCU reads again
        armed <= 1'b0;
        irq   <= 1'b1;
      end
      // acknowledge beats a new request in the same cycle
      if (iack) begin
        irq <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/hid_device_regs.sv
//############################################################
// mouse, joystick and numpad registers fed by MCU frames
// joystick bytes for unknown devices are dropped
//############################################################
`timescale 1ns/1ps

module hid_device_regs (
  input  logic              clk,
  input  logic              reset,
  input  hid_pkg::hid_cmd_e cmd,
  input  logic [3:0]        byte_index,
  input  logic              payload_valid,
  input  logic [7:0]        payload,
  output logic [7:0]        joystick0,
  output logic [7:0]        joystick1,
  output logic [7:0]        numpad,
  output logic [1:0]        mouse_btns,
  output logic [7:0]        mouse_x,
  output logic [7:0]        mouse_y,
  output logic              mouse_strobe,
  output logic              key_restore
);

  import hid_pkg::*;

  // target of the next joystick byte
  hid_joy_dev_e device;

  logic mouse_wr;
  logic joy_wr;

  assign mouse_wr = payload_valid && (cmd == CMD_MOUSE);
  assign joy_wr   = payload_valid && (cmd == CMD_JOYSTICK);

  always_ff @(posedge clk) begin
    if (joy_wr && byte_index == 4'd1) begin
      device <= hid_joy_dev_e'(payload);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      joystick0    <= 8'd0;
      joystick1    <= 8'd0;
      numpad       <= 8'd0;
      mouse_btns   <= 2'd0;
      mouse_x      <= 8'd0;
      mouse_y      <= 8'd0;
      mouse_strobe <= 1'b0;
      key_restore  <= 1'b0;
    end else begin
      // strobe marks a complete mouse report
      mouse_strobe <= mouse_wr && (byte_index == 4'd3);

      if (mouse_wr) begin
        case (byte_index)
          4'd1: mouse_btns <= payload[1:0];
          4'd2: mouse_x    <= payload;
          4'd3: mouse_y    <= payload;
          default: ;
        endcase
      end

      if (joy_wr && byte_index == 4'd2) begin
        case (device)
          JOY_DEV_0: joystick0 <= payload;
          JOY_DEV_1: joystick1 <= payload;
          JOY_DEV_NUMPAD: begin
            numpad      <= payload;
            key_restore <= payload[RESTORE_BIT];
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: rtl/hid_frame_parser.sv
//############################################################
// decodes the strobe/start byte stream into command, index
// and payload; payload before the first command is dropped
//############################################################
`timescale 1ns/1ps

module hid_frame_parser (
  input  logic              clk,
  input  logic              reset,
  input  logic              data_in_strobe,
  input  logic              data_in_start,
  input  logic [7:0]        data_in,
  output hid_pkg::hid_cmd_e cmd,
  output logic [3:0]        byte_index,
  output logic              payload_valid,
  output logic [7:0]        payload,
  output logic              rearm
);

  import hid_pkg::*;

  // index 0 means no frame has been opened yet
  assign payload_valid = data_in_strobe && !data_in_start && (byte_index != 4'd0);
  assign payload       = data_in;

  // first payload byte of a DB9 read re-arms the monitor
  assign rearm = payload_valid && (cmd == CMD_DB9_READ) && (byte_index == 4'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd        <= CMD_STATUS;
      byte_index <= 4'd0;
    end else if (data_in_strobe) begin
      if (data_in_start) begin
        // unknown codes are kept and simply match no sink
        cmd        <= hid_cmd_e'(data_in);
        byte_index <= 4'd1;
      end else if (byte_index != 4'd0 && byte_index != MAX_BYTE_INDEX) begin
        byte_index <= byte_index + 4'd1;
      end
    end
  end

endmodule

// File: rtl/hid_key_matrix.sv
//############################################################
// 8x8 key matrix, low level means key pressed
// column scan from the core is active low and combinational
//############################################################
`timescale 1ns/1ps

module hid_key_matrix (
  input  logic              clk,
  input  logic              reset,
  input  hid_pkg::hid_cmd_e cmd,
  input  logic [3:0]        byte_index,
  input  logic              payload_valid,
  input  logic [7:0]        payload,
  input  logic [7:0]        keyboard_matrix_out,
  output logic [7:0]        keyboard_matrix_in
);

  import hid_pkg::*;

  // one byte per row, one bit per column
  logic [7:0] key_state [8];

  logic [2:0] key_row;
  logic [2:0] key_col;
  logic       key_write;

  assign key_row   = payload[KEY_ROW_LSB +: 3];
  assign key_col   = payload[KEY_COL_LSB +: 3];
  assign key_write = payload_valid && (cmd == CMD_KEYBOARD) && (byte_index == 4'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      // all keys released
      key_state <= '{default: 8'hff};
    end else if (key_write) begin
      key_state[key_row][key_col] <= payload[KEY_RELEASE_BIT];
    end
  end

  // selected rows are ANDed, idle lines read high
  always_comb begin
    keyboard_matrix_in = 8'hff;
    for (int i = 0; i < 8; i++) begin
      if (!keyboard_matrix_out[i]) begin
        keyboard_matrix_in = keyboard_matrix_in & key_state[i];
      end
    end
  end

endmodule

// File: rtl/hid_pkg.sv
//############################################################
// shared types and byte layout for the HID frame interface
// command and device codes follow the MCU byte protocol
//############################################################

package hid_pkg;

  // command byte sent with data_in_start
  typedef enum logic [7:0] {
    CMD_STATUS   = 8'd0,
    CMD_KEYBOARD = 8'd1,
    CMD_MOUSE    = 8'd2,
    CMD_JOYSTICK = 8'd3,
    CMD_DB9_READ = 8'd4
  } hid_cmd_e;

  // device byte at index 1 of a joystick frame
  typedef enum logic [7:0] {
    JOY_DEV_0      = 8'd0,
    JOY_DEV_1      = 8'd1,
    JOY_DEV_NUMPAD = 8'h80
  } hid_joy_dev_e;

  // byte index stops counting here
  localparam logic [3:0] MAX_BYTE_INDEX = 4'd15;

  // key event byte
  // bit 7 is the new key level with 0 meaning pressed
  // bits 2..0 select the row and bits 5..3 the column
  localparam int KEY_RELEASE_BIT = 7;
  localparam int KEY_ROW_LSB     = 0;
  localparam int KEY_COL_LSB     = 3;

  // numpad bit carrying the restore key
  localparam int RESTORE_BIT = 6;

endpackage

// File: rtl/hid_reply.sv
//############################################################
// registered reply byte returned to the MCU
// holds its value until the next payload byte
//############################################################
`timescale 1ns/1ps

module hid_reply #(
  parameter int          DB9_WIDTH   = 6,
  parameter logic [15:0] STATUS_WORD = 16'h5c42
) (
  input  logic                 clk,
  input  logic                 reset,
  input  hid_pkg::hid_cmd_e    cmd,
  input  logic [3:0]           byte_index,
  input  logic                 payload_valid,
  input  logic [DB9_WIDTH-1:0] db9_port,
  input  logic [DB9_WIDTH-1:0] db9_snapshot,
  output logic [7:0]           data_out
);

  import hid_pkg::*;

  logic [DB9_WIDTH-1:0] db9_value;

  // snapshot is taken at index 1, so live port equals it there
  assign db9_value = (byte_index == 4'd1) ? db9_port : db9_snapshot;

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= 8'd0;
    end else if (payload_valid) begin
      case (cmd)
        CMD_STATUS: begin
          if (byte_index == 4'd1) data_out <= STATUS_WORD[15:8];
          if (byte_index == 4'd2) data_out <= STATUS_WORD[7:0];
        end
        CMD_DB9_READ: data_out <= 8'(db9_value);
        default: ;
      endcase
    end
  end

endmodule

// File: rtl/hid_top.sv
//############################################################
// HID block between the IO MCU byte stream and the core
// no back-pressure, strobes may arrive every cycle
// unknown commands are ignored
//############################################################
`timescale 1ns/1ps

module hid_top #(
  parameter int          DB9_WIDTH   = 6,
  parameter logic [15:0] STATUS_WORD = 16'h5c42
) (
  input  logic                 clk,
  input  logic                 reset,

  // MCU byte stream
  input  logic                 data_in_strobe,
  input  logic                 data_in_start,
  input  logic [7:0]           data_in,
  output logic [7:0]           data_out,

  // local joystick port and its interrupt
  input  logic [DB9_WIDTH-1:0] db9_port,
  output logic                 irq,
  input  logic                 iack,

  // core side
  output logic [7:0]           joystick0,
  output logic [7:0]           joystick1,
  output logic [7:0]           numpad,
  input  logic [7:0]           keyboard_matrix_out,
  output logic [7:0]           keyboard_matrix_in,
  output logic                 key_restore,
  output logic [1:0]           mouse_btns,
  output logic [7:0]           mouse_x,
  output logic [7:0]           mouse_y,
  output logic                 mouse_strobe
);

  import hid_pkg::*;

  hid_cmd_e             cmd;
  logic [3:0]           byte_index;
  logic                 payload_valid;
  logic [7:0]           payload;
  logic                 rearm;
  logic [DB9_WIDTH-1:0] db9_snapshot;

  hid_frame_parser u_parser (
    .clk            (clk),
    .reset          (reset),
    .data_in_strobe (data_in_strobe),
    .data_in_start  (data_in_start),
    .data_in        (data_in),
    .cmd            (cmd),
    .byte_index     (byte_index),
    .payload_valid  (payload_valid),
    .payload        (payload),
    .rearm          (rearm)
  );

  db9_monitor #(
    .DB9_WIDTH (DB9_WIDTH)
  ) u_db9_monitor (
    .clk          (clk),
    .reset        (reset),
    .db9_port     (db9_port),
    .rearm        (rearm),
    .iack         (iack),
    .irq          (irq),
    .db9_snapshot (db9_snapshot)
  );

  hid_key_matrix u_key_matrix (
    .clk                 (clk),
    .reset               (reset),
    .cmd                 (cmd),
    .byte_index          (byte_index),
    .payload_valid       (payload_valid),
    .payload             (payload),
    .keyboard_matrix_out (keyboard_matrix_out),
    .keyboard_matrix_in  (keyboard_matrix_in)
  );

  hid_device_regs u_device_regs (
    .clk           (clk),
    .reset         (reset),
    .cmd           (cmd),
    .byte_index    (byte_index),
    .payload_valid (payload_valid),
    .payload       (payload),
    .joystick0     (joystick0),
    .joystick1     (joystick1),
    .numpad        (numpad),
    .mouse_btns    (mouse_btns),
    .mouse_x       (mouse_x),
    .mouse_y       (mouse_y),
    .mouse_strobe  (mouse_strobe),
    .key_restore   (key_restore)
  );

  hid_reply #(
    .DB9_WIDTH   (DB9_WIDTH),
    .STATUS_WORD (STATUS_WORD)
  ) u_reply (
    .clk           (clk),
    .reset         (reset),
    .cmd           (cmd),
    .byte_index    (byte_index),
    .payload_valid (payload_valid),
    .db9_port      (db9_port),
    .db9_snapshot  (db9_snapshot),
    .data_out      (data_out)
  );

endmodule
